// ==== Makefile ====
# Verilator build and run of the write-channel watchdog testbench
VERILATOR ?= verilator
TOP       ?= tb_write_guard
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
logic/wg_axi_pkg.sv
logic/wg_reg_pkg.sv
logic/wg_config_regs.sv
logic/wg_w_order_fifo.sv
logic/wg_txn_table.sv
logic/write_guard.sv
verif/tb_write_guard.sv

// ==== include/wg_config.svh ====
// Build-time configuration of the write-channel watchdog
// Included by every RTL file and by the testbench
`ifndef WG_CONFIG_SVH
`define WG_CONFIG_SVH

// Outstanding write transactions tracked at once
`define WG_NUM_SLOTS 4

// Field widths of the watched bus
`define WG_ID_W   4
`define WG_ADDR_W 32
`define WG_LEN_W  8

// Width of the phase counters and of the budgets
`define WG_CNT_W 16

// Width of the config register data
`define WG_REG_DATA_W 32

// Budget values after reset, in clock cycles
// W_BEAT is per beat and scaled by the burst length
`define WG_BUDGET_W_FIRST_RST 16
`define WG_BUDGET_W_BEAT_RST  4
`define WG_BUDGET_B_RST       16

`endif

// ==== logic/wg_axi_pkg.sv ====
// Types of the watched write channels and of the per-slot phase tracking
// Imported by the transaction table, the order queue and the top level
`include "wg_config.svh"

package wg_axi_pkg;

  // Fields seen on the AW and B channels
  typedef logic [`WG_ID_W-1:0]   id_t;
  typedef logic [`WG_ADDR_W-1:0] addr_t;

  // AXI burst length, beats minus one
  typedef logic [`WG_LEN_W-1:0]  len_t;

  // Phase counter and budget value
  typedef logic [`WG_CNT_W-1:0]  cnt_t;

  // Index into the slot table
  typedef logic [$clog2(`WG_NUM_SLOTS)-1:0] slot_idx_t;

  // Lifecycle of one tracked write
  typedef enum logic [1:0] {
    FREE    = 2'd0,
    W_WAIT  = 2'd1,
    W_BURST = 2'd2,
    B_WAIT  = 2'd3
  } phase_e;

endpackage

// ==== logic/wg_config_regs.sv ====
// Budget registers and first-fault capture of the watchdog
// Written by single-cycle strobes, read back combinationally by address
`timescale 1ns/1ps
`include "wg_config.svh"

module wg_config_regs
  import wg_axi_pkg::*;
  import wg_reg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cfg_we_i,
  input  reg_addr_e    cfg_addr_i,
  input  reg_data_t    cfg_wdata_i,
  output reg_data_t    cfg_rdata_o,
  input  logic         fault_valid_i,
  input  fault_cause_e fault_cause_i,
  input  id_t          fault_id_i,
  input  addr_t        fault_addr_i,
  output cnt_t         budget_w_first_o,
  output cnt_t         budget_w_beat_o,
  output cnt_t         budget_b_o,
  output logic         fault_active_o,
  output logic         irq_o,
  output logic         reset_req_o
);

  cnt_t         budget_w_first_q;
  cnt_t         budget_w_beat_q;
  cnt_t         budget_b_q;
  logic         fault_active_q;
  fault_cause_e fault_cause_q;
  id_t          fault_id_q;
  addr_t        fault_addr_q;
  logic         clear_req;

  // Bit 0 of a REG_CLEAR write releases the fault
  assign clear_req = cfg_we_i && (cfg_addr_i == REG_CLEAR) && cfg_wdata_i[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budget_w_first_q <= cnt_t'(`WG_BUDGET_W_FIRST_RST);
      budget_w_beat_q  <= cnt_t'(`WG_BUDGET_W_BEAT_RST);
      budget_b_q       <= cnt_t'(`WG_BUDGET_B_RST);
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        REG_BUDGET_W_FIRST: budget_w_first_q <= cfg_wdata_i[`WG_CNT_W-1:0];
        REG_BUDGET_W_BEAT:  budget_w_beat_q  <= cfg_wdata_i[`WG_CNT_W-1:0];
        REG_BUDGET_B:       budget_b_q       <= cfg_wdata_i[`WG_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  // First fault wins until software clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_active_q <= 1'b0;
      fault_cause_q  <= FAULT_NONE;
      fault_id_q     <= '0;
      fault_addr_q   <= '0;
    end else if (fault_valid_i && !fault_active_q) begin
      fault_active_q <= 1'b1;
      fault_cause_q  <= fault_cause_i;
      fault_id_q     <= fault_id_i;
      fault_addr_q   <= fault_addr_i;
    end else if (clear_req) begin
      fault_active_q <= 1'b0;
      fault_cause_q  <= FAULT_NONE;
    end
  end

  // Read mux with narrower registers zero-extended
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      REG_BUDGET_W_FIRST: cfg_rdata_o[`WG_CNT_W-1:0] = budget_w_first_q;
      REG_BUDGET_W_BEAT:  cfg_rdata_o[`WG_CNT_W-1:0] = budget_w_beat_q;
      REG_BUDGET_B:       cfg_rdata_o[`WG_CNT_W-1:0] = budget_b_q;
      REG_FAULT_CAUSE:    cfg_rdata_o[$bits(fault_cause_e)-1:0] = fault_cause_q;
      REG_FAULT_ID:       cfg_rdata_o[`WG_ID_W-1:0] = fault_id_q;
      REG_FAULT_ADDR:     cfg_rdata_o[`WG_ADDR_W-1:0] = fault_addr_q;
      default:            cfg_rdata_o = '0;
    endcase
  end

  assign budget_w_first_o = budget_w_first_q;
  assign budget_w_beat_o  = budget_w_beat_q;
  assign budget_b_o       = budget_b_q;
  assign fault_active_o   = fault_active_q;

  // Both outputs follow the latched fault
  assign irq_o       = fault_active_q;
  assign reset_req_o = fault_active_q;

endmodule

// ==== logic/wg_reg_pkg.sv ====
// Register view of the watchdog
// Holds the register map, the fault cause encoding and the data type
`include "wg_config.svh"

package wg_reg_pkg;

  // Register map, one word per address
  typedef enum logic [2:0] {
    REG_BUDGET_W_FIRST = 3'd0,
    REG_BUDGET_W_BEAT  = 3'd1,
    REG_BUDGET_B       = 3'd2,
    REG_FAULT_CAUSE    = 3'd3,
    REG_FAULT_ID       = 3'd4,
    REG_FAULT_ADDR     = 3'd5,
    REG_CLEAR          = 3'd6
  } reg_addr_e;

  // Reason for the latched fault
  typedef enum logic [2:0] {
    FAULT_NONE       = 3'd0,
    FAULT_W_FIRST    = 3'd1,
    FAULT_W_BURST    = 3'd2,
    FAULT_B          = 3'd3,
    FAULT_UNWANTED_B = 3'd4,
    FAULT_OVERFLOW   = 3'd5
  } fault_cause_e;

  // Config write and read data
  typedef logic [`WG_REG_DATA_W-1:0] reg_data_t;

endpackage

// ==== logic/wg_txn_table.sv ====
// Slot table that times every outstanding write through its three phases
// Reports at most one fault per cycle and flushes all slots when it does
`timescale 1ns/1ps
`include "wg_config.svh"

module wg_txn_table
  import wg_axi_pkg::*;
  import wg_reg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         aw_valid_i,
  input  logic         aw_ready_i,
  input  id_t          aw_id_i,
  input  addr_t        aw_addr_i,
  input  len_t         aw_len_i,
  input  logic         w_valid_i,
  input  logic         w_ready_i,
  input  logic         w_last_i,
  input  logic         b_valid_i,
  input  logic         b_ready_i,
  input  id_t          b_id_i,
  input  cnt_t         budget_w_first_i,
  input  cnt_t         budget_w_beat_i,
  input  cnt_t         budget_b_i,
  input  logic         fault_active_i,
  input  slot_idx_t    order_head_i,
  input  logic         order_empty_i,
  output logic         order_push_o,
  output slot_idx_t    order_push_idx_o,
  output logic         order_pop_o,
  output logic         flush_o,
  output logic         fault_valid_o,
  output fault_cause_e fault_cause_o,
  output id_t          fault_id_o,
  output addr_t        fault_addr_o
);

  localparam int unsigned NumSlots = `WG_NUM_SLOTS;
  localparam int unsigned SeqW     = $clog2(NumSlots) + 1;
  localparam int unsigned LimW     = `WG_CNT_W + `WG_LEN_W + 1;

  typedef logic [SeqW-1:0] seq_t;
  typedef logic [LimW-1:0] lim_t;

  phase_e phase_q [NumSlots];
  phase_e phase_d [NumSlots];
  cnt_t   cnt_q   [NumSlots];
  cnt_t   cnt_d   [NumSlots];
  id_t    id_q    [NumSlots];
  addr_t  addr_q  [NumSlots];
  len_t   len_q   [NumSlots];
  seq_t   seq_q   [NumSlots];
  seq_t   alloc_seq_q;

  logic                aw_hs, w_hs, b_hs;
  logic                aw_accept, aw_overflow, b_unwanted;
  logic                any_free, b_found, any_over;
  slot_idx_t           free_idx, b_idx, over_idx;
  logic [NumSlots-1:0] w_own, b_done, over;

  assign aw_hs = aw_valid_i && aw_ready_i;
  assign w_hs  = w_valid_i && w_ready_i;
  assign b_hs  = b_valid_i && b_ready_i;

  // AWs are ignored while a fault is latched
  assign aw_accept   = aw_hs && !fault_active_i && any_free;
  assign aw_overflow = aw_hs && !fault_active_i && !any_free;
  assign b_unwanted  = b_hs && !b_found;

  assign order_push_o     = aw_accept;
  assign order_push_idx_o = free_idx;
  assign order_pop_o      = w_hs && w_last_i && !order_empty_i;

  // Lowest free slot
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (phase_q[i] == FREE) begin
        any_free = 1'b1;
        free_idx = slot_idx_t'(i);
      end
    end
  end

  // Oldest B_WAIT slot with the response ID by allocation sequence
  always_comb begin
    seq_t age;
    seq_t best_age;
    b_found  = 1'b0;
    b_idx    = '0;
    best_age = '0;
    for (int i = 0; i < NumSlots; i++) begin
      age = alloc_seq_q - seq_q[i];
      if (phase_q[i] == B_WAIT && id_q[i] == b_id_i && (!b_found || age > best_age)) begin
        b_found  = 1'b1;
        b_idx    = slot_idx_t'(i);
        best_age = age;
      end
    end
  end

  // Phase moves and budget checks per slot
  always_comb begin
    lim_t burst_limit;
    for (int i = 0; i < NumSlots; i++) begin
      w_own[i]    = w_hs && !order_empty_i && (order_head_i == slot_idx_t'(i));
      b_done[i]   = b_hs && b_found && (b_idx == slot_idx_t'(i));
      burst_limit = lim_t'(budget_w_beat_i) * (lim_t'(len_q[i]) + lim_t'(1));
      case (phase_q[i])
        W_WAIT:  over[i] = !w_own[i] && (cnt_q[i] >= budget_w_first_i);
        W_BURST: over[i] = !(w_own[i] && w_last_i) && (lim_t'(cnt_q[i]) >= burst_limit);
        B_WAIT:  over[i] = !b_done[i] && (cnt_q[i] >= budget_b_i);
        default: over[i] = 1'b0;
      endcase
    end
  end

  // Lowest overrunning slot
  always_comb begin
    any_over = 1'b0;
    over_idx = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (over[i]) begin
        any_over = 1'b1;
        over_idx = slot_idx_t'(i);
      end
    end
  end

  // Fault report in priority order of overrun, unwanted B and overflow
  always_comb begin
    fault_valid_o = 1'b0;
    fault_cause_o = FAULT_NONE;
    fault_id_o    = '0;
    fault_addr_o  = '0;
    if (any_over) begin
      fault_valid_o = 1'b1;
      fault_id_o    = id_q[over_idx];
      fault_addr_o  = addr_q[over_idx];
      case (phase_q[over_idx])
        W_WAIT:  fault_cause_o = FAULT_W_FIRST;
        W_BURST: fault_cause_o = FAULT_W_BURST;
        default: fault_cause_o = FAULT_B;
      endcase
    end else if (b_unwanted) begin
      fault_valid_o = 1'b1;
      fault_cause_o = FAULT_UNWANTED_B;
      fault_id_o    = b_id_i;
    end else if (aw_overflow) begin
      fault_valid_o = 1'b1;
      fault_cause_o = FAULT_OVERFLOW;
      fault_id_o    = aw_id_i;
      fault_addr_o  = aw_addr_i;
    end
  end

  assign flush_o = fault_valid_o;

  // Next phase and counter where any phase move restarts the counter
  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      phase_d[i] = phase_q[i];
      cnt_d[i]   = (cnt_q[i] == '1) ? cnt_q[i] : cnt_q[i] + cnt_t'(1);
      case (phase_q[i])
        FREE: begin
          if (aw_accept && free_idx == slot_idx_t'(i)) begin
            phase_d[i] = W_WAIT;
            cnt_d[i]   = '0;
          end
        end
        W_WAIT: begin
          // Single-beat burst skips W_BURST
          if (w_own[i]) begin
            phase_d[i] = w_last_i ? B_WAIT : W_BURST;
            cnt_d[i]   = '0;
          end
        end
        W_BURST: begin
          if (w_own[i] && w_last_i) begin
            phase_d[i] = B_WAIT;
            cnt_d[i]   = '0;
          end
        end
        default: begin
          if (b_done[i]) begin
            phase_d[i] = FREE;
            cnt_d[i]   = '0;
          end
        end
      endcase
      if (fault_valid_o) begin
        phase_d[i] = FREE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumSlots; i++) begin
        phase_q[i] <= FREE;
      end
      alloc_seq_q <= '0;
    end else begin
      for (int i = 0; i < NumSlots; i++) begin
        phase_q[i] <= phase_d[i];
      end
      if (aw_accept) begin
        alloc_seq_q <= alloc_seq_q + seq_t'(1);
      end
    end
  end

  // Counters and captured AW fields
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumSlots; i++) begin
      cnt_q[i] <= cnt_d[i];
      if (aw_accept && free_idx == slot_idx_t'(i)) begin
        id_q[i]   <= aw_id_i;
        addr_q[i] <= aw_addr_i;
        len_q[i]  <= aw_len_i;
        seq_q[i]  <= alloc_seq_q;
      end
    end
  end

endmodule

// ==== logic/wg_w_order_fifo.sv ====
// Queue of slot indices in AW order
// The head entry names the slot that currently owns the W channel
`timescale 1ns/1ps
`include "wg_config.svh"

module wg_w_order_fifo
  import wg_axi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  slot_idx_t push_idx_i,
  input  logic      pop_i,
  input  logic      flush_i,
  output slot_idx_t head_idx_o,
  output logic      empty_o
);

  localparam int unsigned Depth  = `WG_NUM_SLOTS;
  localparam int unsigned CountW = $clog2(Depth + 1);

  slot_idx_t         mem_q [Depth];
  slot_idx_t         wr_ptr_q;
  slot_idx_t         rd_ptr_q;
  logic [CountW-1:0] count_q;
  logic              do_push;
  logic              do_pop;

  function automatic slot_idx_t ptr_inc(input slot_idx_t ptr);
    if (ptr == slot_idx_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + slot_idx_t'(1);
  endfunction

  // Never full on push since the table only pushes a slot it just allocated
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop keep the fill level
      if (do_push && !do_pop) begin
        count_q <= count_q + CountW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CountW'(1);
      end
    end
  end

  assign head_idx_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);

endmodule

// ==== logic/write_guard.sv ====
// Write-channel watchdog top level
// Watches AW, W and B of one link and raises irq_o and reset_req_o on a fault
`timescale 1ns/1ps
`include "wg_config.svh"

module write_guard
  import wg_axi_pkg::*;
  import wg_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      aw_valid_i,
  input  logic      aw_ready_i,
  input  id_t       aw_id_i,
  input  addr_t     aw_addr_i,
  input  len_t      aw_len_i,
  input  logic      w_valid_i,
  input  logic      w_ready_i,
  input  logic      w_last_i,
  input  logic      b_valid_i,
  input  logic      b_ready_i,
  input  id_t       b_id_i,
  input  logic      cfg_we_i,
  input  reg_addr_e cfg_addr_i,
  input  reg_data_t cfg_wdata_i,
  output reg_data_t cfg_rdata_o,
  output logic      irq_o,
  output logic      reset_req_o
);

  cnt_t         budget_w_first;
  cnt_t         budget_w_beat;
  cnt_t         budget_b;
  logic         fault_active;
  logic         fault_valid;
  fault_cause_e fault_cause;
  id_t          fault_id;
  addr_t        fault_addr;
  logic         order_push;
  slot_idx_t    order_push_idx;
  logic         order_pop;
  logic         order_flush;
  slot_idx_t    order_head;
  logic         order_empty;

  wg_config_regs u_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .cfg_rdata_o      (cfg_rdata_o),
    .fault_valid_i    (fault_valid),
    .fault_cause_i    (fault_cause),
    .fault_id_i       (fault_id),
    .fault_addr_i     (fault_addr),
    .budget_w_first_o (budget_w_first),
    .budget_w_beat_o  (budget_w_beat),
    .budget_b_o       (budget_b),
    .fault_active_o   (fault_active),
    .irq_o            (irq_o),
    .reset_req_o      (reset_req_o)
  );

  wg_txn_table u_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .aw_valid_i       (aw_valid_i),
    .aw_ready_i       (aw_ready_i),
    .aw_id_i          (aw_id_i),
    .aw_addr_i        (aw_addr_i),
    .aw_len_i         (aw_len_i),
    .w_valid_i        (w_valid_i),
    .w_ready_i        (w_ready_i),
    .w_last_i         (w_last_i),
    .b_valid_i        (b_valid_i),
    .b_ready_i        (b_ready_i),
    .b_id_i           (b_id_i),
    .budget_w_first_i (budget_w_first),
    .budget_w_beat_i  (budget_w_beat),
    .budget_b_i       (budget_b),
    .fault_active_i   (fault_active),
    .order_head_i     (order_head),
    .order_empty_i    (order_empty),
    .order_push_o     (order_push),
    .order_push_idx_o (order_push_idx),
    .order_pop_o      (order_pop),
    .flush_o          (order_flush),
    .fault_valid_o    (fault_valid),
    .fault_cause_o    (fault_cause),
    .fault_id_o       (fault_id),
    .fault_addr_o     (fault_addr)
  );

  // W ownership follows AW order
  wg_w_order_fifo u_order (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (order_push),
    .push_idx_i (order_push_idx),
    .pop_i      (order_pop),
    .flush_i    (order_flush),
    .head_idx_o (order_head),
    .empty_o    (order_empty)
  );

endmodule

// ==== verif/tb_write_guard.sv ====
// Testbench for the write-channel watchdog
// Drives random and directed AW, W and B traffic and checks irq_o, reset_req_o
// and the fault registers against a model of the watchdog rules
`timescale 1ns/1ps
`include "wg_config.svh"

module tb_write_guard
  import wg_axi_pkg::*;
  import wg_reg_pkg::*;
();

  localparam int NumRandom     = 200;
  localparam int NumRecover    = 20;
  localparam int NumDirected   = 12;
  localparam int TimeoutCycles = 40 * (NumRandom + NumRecover + NumDirected) + 2000;

  logic      clk_i;
  logic      rst_ni;
  logic      aw_valid_i;
  logic      aw_ready_i;
  id_t       aw_id_i;
  addr_t     aw_addr_i;
  len_t      aw_len_i;
  logic      w_valid_i;
  logic      w_ready_i;
  logic      w_last_i;
  logic      b_valid_i;
  logic      b_ready_i;
  id_t       b_id_i;
  logic      cfg_we_i;
  reg_addr_e cfg_addr_i;
  reg_data_t cfg_wdata_i;
  reg_data_t cfg_rdata_o;
  logic      irq_o;
  logic      reset_req_o;

  int   seed;
  int   cycle_cnt;
  logic mon_en;

  // Model of outstanding writes and of the latched fault
  id_t          pend_id [$];
  logic         exp_active;
  fault_cause_e exp_cause;
  id_t          exp_id;
  addr_t        exp_addr;
  int           bud_first;
  int           bud_beat;
  int           bud_b;

  write_guard write_guard_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_i  (aw_ready_i),
    .aw_id_i     (aw_id_i),
    .aw_addr_i   (aw_addr_i),
    .aw_len_i    (aw_len_i),
    .w_valid_i   (w_valid_i),
    .w_ready_i   (w_ready_i),
    .w_last_i    (w_last_i),
    .b_valid_i   (b_valid_i),
    .b_ready_i   (b_ready_i),
    .b_id_i      (b_id_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .irq_o       (irq_o),
    .reset_req_o (reset_req_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // Outputs must follow the model while traffic runs
  always @(negedge clk_i) begin
    if (mon_en) begin
      check_value("irq during traffic", 32'(exp_active), 32'(irq_o));
      check_value("reset_req during traffic", 32'(exp_active), 32'(reset_req_o));
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic bus_quiet();
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    w_last_i   <= 1'b0;
    b_valid_i  <= 1'b0;
  endtask

  // A beat driven by these tasks handshakes at the edge after the task returns
  // Now and then the beat first waits one cycle with ready low
  task automatic send_aw(input id_t id, input addr_t addr, input len_t len);
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i   <= 1'b0;
    aw_valid_i <= 1'b1;
    aw_id_i    <= id;
    aw_addr_i  <= addr;
    aw_len_i   <= len;
    if ({$random(seed)} % 4 == 0) begin
      aw_ready_i <= 1'b0;
      @(posedge clk_i);
      aw_ready_i <= 1'b1;
    end
  endtask

  task automatic send_w(input logic last);
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i  <= 1'b0;
    w_valid_i <= 1'b1;
    w_last_i  <= last;
    if ({$random(seed)} % 4 == 0) begin
      w_ready_i <= 1'b0;
      @(posedge clk_i);
      w_ready_i <= 1'b1;
    end
  endtask

  task automatic send_b(input id_t id);
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i  <= 1'b0;
    b_valid_i <= 1'b1;
    b_id_i    <= id;
    if ({$random(seed)} % 4 == 0) begin
      b_ready_i <= 1'b0;
      @(posedge clk_i);
      b_ready_i <= 1'b1;
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i <= 1'b0;
  endtask

  task automatic random_gap();
    repeat ({$random(seed)} % 2) go_idle();
  endtask

  task automatic reg_write(input reg_addr_e addr, input reg_data_t data);
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e addr, output reg_data_t data);
    @(posedge clk_i);
    bus_quiet();
    cfg_we_i   <= 1'b0;
    cfg_addr_i <= addr;
    @(negedge clk_i);
    data = cfg_rdata_o;
  endtask

  // First fault wins until a clear
  function automatic void model_fault(input fault_cause_e cause, input id_t id,
                                      input addr_t addr);
    if (!exp_active) begin
      exp_active = 1'b1;
      exp_cause  = cause;
      exp_id     = id;
      exp_addr   = addr;
    end
  endfunction

  // Counts edges after the last handshake until irq_o is seen high
  task automatic wait_for_irq(input string name, input int expected_edges);
    int n;
    n = 0;
    @(negedge clk_i);
    while (irq_o !== 1'b1 && n < 4 * expected_edges + 16) begin
      n++;
      @(negedge clk_i);
    end
    check_value({name, " edges to irq"}, 32'(expected_edges), 32'(n));
    check_value({name, " reset_req"}, 32'd1, 32'(reset_req_o));
  endtask

  task automatic check_fault_regs(input string name, input logic with_addr);
    reg_data_t rd;
    reg_read(REG_FAULT_CAUSE, rd);
    check_value({name, " cause"}, 32'(exp_cause), rd);
    reg_read(REG_FAULT_ID, rd);
    check_value({name, " id"}, 32'(exp_id), rd);
    if (with_addr) begin
      reg_read(REG_FAULT_ADDR, rd);
      check_value({name, " addr"}, 32'(exp_addr), rd);
    end
    check_value({name, " irq"}, 32'(exp_active), 32'(irq_o));
    check_value({name, " reset_req"}, 32'(exp_active), 32'(reset_req_o));
  endtask

  task automatic clear_fault(input string name);
    reg_data_t rd;
    reg_write(REG_CLEAR, 32'd1);
    exp_active = 1'b0;
    exp_cause  = FAULT_NONE;
    @(negedge clk_i);
    check_value({name, " irq after clear"}, 32'd0, 32'(irq_o));
    check_value({name, " reset_req after clear"}, 32'd0, 32'(reset_req_o));
    reg_read(REG_FAULT_CAUSE, rd);
    check_value({name, " cause after clear"}, 32'(exp_cause), rd);
  endtask

  // Returns every pending B in a random order
  task automatic drain_responses();
    int k;
    while (pend_id.size() > 0) begin
      k = int'({$random(seed)} % pend_id.size());
      random_gap();
      send_b(pend_id[k]);
      pend_id.delete(k);
    end
  endtask

  task automatic run_traffic(input int count);
    id_t   id;
    addr_t addr;
    len_t  len;
    int    coin;
    for (int t = 0; t < count; t++) begin
      id   = id_t'($random(seed));
      addr = addr_t'($random(seed));
      len  = len_t'({$random(seed)} % 4);
      random_gap();
      send_aw(id, addr, len);
      pend_id.push_back(id);
      for (int b = 0; b <= int'(len); b++) begin
        random_gap();
        send_w(b == int'(len));
      end
      // No more than two writes wait for B at once
      coin = int'({$random(seed)} % 2);
      if (pend_id.size() == 2 || coin == 1) begin
        drain_responses();
      end
    end
    drain_responses();
    go_idle();
  endtask

  // Stops the write after a number of W beats and waits for the overrun
  task automatic stall_test(input string name, input fault_cause_e cause, input len_t len,
                            input int beats, input int budget);
    id_t   id;
    addr_t addr;
    id   = id_t'($random(seed));
    addr = addr_t'($random(seed));
    send_aw(id, addr, len);
    for (int i = 0; i < beats; i++) begin
      send_w(i == int'(len));
    end
    go_idle();
    model_fault(cause, id, addr);
    wait_for_irq(name, budget + 1);
    check_fault_regs(name, 1'b1);
    clear_fault(name);
  endtask

  initial begin
    reg_data_t rd;
    id_t       id;
    addr_t     addr;
    seed        = 32'h82f1;
    cycle_cnt   = 0;
    mon_en      = 1'b0;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    aw_valid_i  = 1'b0;
    aw_ready_i  = 1'b1;
    aw_id_i     = '0;
    aw_addr_i   = '0;
    aw_len_i    = '0;
    w_valid_i   = 1'b0;
    w_ready_i   = 1'b1;
    w_last_i    = 1'b0;
    b_valid_i   = 1'b0;
    b_ready_i   = 1'b1;
    b_id_i      = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = REG_BUDGET_W_FIRST;
    cfg_wdata_i = '0;
    exp_active  = 1'b0;
    exp_cause   = FAULT_NONE;
    exp_id      = '0;
    exp_addr    = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset state and budget read-back
    @(negedge clk_i);
    check_value("reset irq", 32'd0, 32'(irq_o));
    check_value("reset reset_req", 32'd0, 32'(reset_req_o));
    reg_read(REG_BUDGET_W_FIRST, rd);
    check_value("reset budget w_first", 32'(`WG_BUDGET_W_FIRST_RST), rd);
    reg_read(REG_BUDGET_W_BEAT, rd);
    check_value("reset budget w_beat", 32'(`WG_BUDGET_W_BEAT_RST), rd);
    reg_read(REG_BUDGET_B, rd);
    check_value("reset budget b", 32'(`WG_BUDGET_B_RST), rd);
    reg_read(REG_FAULT_CAUSE, rd);
    check_value("reset cause", 32'(FAULT_NONE), rd);
    reg_read(REG_CLEAR, rd);
    check_value("clear reads zero", 32'd0, rd);
    bud_first = 24;
    bud_beat  = 6;
    bud_b     = 24;
    reg_write(REG_BUDGET_W_FIRST, reg_data_t'(bud_first));
    reg_write(REG_BUDGET_W_BEAT, reg_data_t'(bud_beat));
    reg_write(REG_BUDGET_B, reg_data_t'(bud_b));
    reg_read(REG_BUDGET_W_FIRST, rd);
    check_value("budget w_first write", 32'(bud_first), rd);
    reg_read(REG_BUDGET_W_BEAT, rd);
    check_value("budget w_beat write", 32'(bud_beat), rd);
    reg_read(REG_BUDGET_B, rd);
    check_value("budget b write", 32'(bud_b), rd);

    // In-time random traffic
    mon_en = 1'b1;
    run_traffic(NumRandom);
    mon_en = 1'b0;
    reg_read(REG_FAULT_CAUSE, rd);
    check_value("traffic cause", 32'(FAULT_NONE), rd);

    // Phase overruns
    stall_test("w_first stall", FAULT_W_FIRST, len_t'(1), 0, bud_first);
    stall_test("w_last stall", FAULT_W_BURST, len_t'(3), 1, bud_beat * 4);
    stall_test("b stall", FAULT_B, len_t'(0), 1, bud_b);

    // B with no tracked write
    id = id_t'($random(seed));
    send_b(id);
    go_idle();
    model_fault(FAULT_UNWANTED_B, id, '0);
    wait_for_irq("unwanted b", 0);
    check_fault_regs("unwanted b", 1'b0);
    clear_fault("unwanted b");

    // AW with every slot busy
    for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
      send_aw(id_t'(i), addr_t'(32'h1000 * (i + 1)), len_t'(0));
    end
    id   = id_t'($random(seed));
    addr = addr_t'($random(seed));
    send_aw(id, addr, len_t'(0));
    go_idle();
    model_fault(FAULT_OVERFLOW, id, addr);
    wait_for_irq("overflow", 0);
    check_fault_regs("overflow", 1'b1);

    // A second fault while latched leaves the capture alone
    send_aw(id_t'(id + id_t'(1)), addr_t'(~addr), len_t'(0));
    send_b(id_t'(id + id_t'(1)));
    go_idle();
    model_fault(FAULT_UNWANTED_B, id_t'(id + id_t'(1)), '0);
    check_fault_regs("fault held", 1'b1);

    // Clear and recovery
    clear_fault("recovery");
    mon_en = 1'b1;
    run_traffic(NumRecover);
    mon_en = 1'b0;
    reg_read(REG_FAULT_CAUSE, rd);
    check_value("recovery cause", 32'(FAULT_NONE), rd);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
